//--- logic/ioPkg.sv
package ioPkg;

    localparam int dataWidth = 16;
    localparam int regWidth = 4;
    localparam int opWidth = 4;

    // I/O window and device offsets within it
    localparam logic [dataWidth-1:0] ioBaseAddr = dataWidth'(384);
    localparam logic [dataWidth-1:0] timerLowerAddr = dataWidth'(8);
    localparam logic [dataWidth-1:0] timerUpperAddr = dataWidth'(11);
    localparam logic [dataWidth-1:0] gpioLowerAddr = dataWidth'(12);
    localparam logic [dataWidth-1:0] gpioUpperAddr = dataWidth'(13);

    localparam int timerCount = 4;
    localparam int wbPortCount = timerCount + 1; // Timers then GPIO

    // Timer minor opcodes
    localparam logic [opWidth-1:0] opTimerLoad = 4'd0;
    localparam logic [opWidth-1:0] opTimerStart = 4'd1;
    localparam logic [opWidth-1:0] opTimerRead = 4'd2;
    localparam logic [opWidth-1:0] opTimerStop = 4'd3;

    // GPIO minor opcodes
    localparam logic [opWidth-1:0] opGpioWrite = 4'd0;
    localparam logic [opWidth-1:0] opGpioRequest = 4'd1;
    localparam logic [opWidth-1:0] opGpioReadBuf = 4'd2;

    typedef struct packed {
        logic [opWidth-1:0]   minorOpcode;
        logic [dataWidth-1:0] addr;
        logic [dataWidth-1:0] data;
        logic [regWidth-1:0]  destReg;
    } cmdT;

    typedef struct packed {
        logic [regWidth-1:0]  destReg;
        logic [dataWidth-1:0] data;
    } wbT;

    typedef struct packed {
        logic                 responseRequested;
        logic [regWidth-1:0]  destReg;
        logic [dataWidth-1:0] data;
    } ioCmdT;

endpackage

//--- logic/writebackArbiter.sv
`timescale 1ns/1ps

module writebackArbiter #(
    parameter int portCount = 2
) (
    input  logic                        sys_clk,
    input  logic                        rstN,

    input  logic [portCount-1:0]        inReq,
    input  ioPkg::wbT [portCount-1:0]   inWb,
    output logic [portCount-1:0]        inAck,

    output logic                        outReq,
    output ioPkg::wbT                   outWb,
    input  logic                        outAck
);
    localparam int idxWidth = (portCount > 1) ? $clog2(portCount) : 1;

    logic busy;
    logic sawAck;
    logic anyReq;
    logic [idxWidth-1:0] grant;
    logic [idxWidth-1:0] lastGrant;
    logic [idxWidth-1:0] nextGrant;

    // Search starts one past the last winner
    always_comb begin
        int cand;
        nextGrant = lastGrant;
        anyReq = 1'b0;
        for (int i = 1; i <= portCount; i++) begin
            cand = (int'(lastGrant) + i) % portCount;
            if (!anyReq && inReq[cand]) begin
                nextGrant = idxWidth'(cand);
                anyReq = 1'b1;
            end
        end
    end

    // Grant is held through all four phases
    always_ff @(posedge sys_clk) begin
        if (!rstN) begin
            busy <= 1'b0;
            sawAck <= 1'b0;
            grant <= '0;
            lastGrant <= idxWidth'(portCount - 1); // Port 0 wins first
        end else if (!busy) begin
            sawAck <= 1'b0;
            if (anyReq) begin
                busy <= 1'b1;
                grant <= nextGrant;
            end
        end else if (outAck) begin
            sawAck <= 1'b1;
        end else if (sawAck) begin
            busy <= 1'b0;
            lastGrant <= grant;
        end
    end

    assign outReq = busy && inReq[grant];
    assign outWb = inWb[grant];

    always_comb begin
        inAck = '0;
        inAck[grant] = busy && outAck;
    end

endmodule

//--- logic/commandTimers.sv
`timescale 1ns/1ps

module commandTimers (
    input  logic                                sys_clk,
    input  logic                                rstN,

    input  logic                                devReq,
    input  ioPkg::cmdT                          cmd,
    output logic                                devAck,

    input  logic [ioPkg::timerCount-1:0]        wbAck,
    output logic [ioPkg::timerCount-1:0]        wbReq,
    output ioPkg::wbT [ioPkg::timerCount-1:0]   wb
);
    logic [ioPkg::timerCount-1:0][ioPkg::dataWidth-1:0] period;
    logic [ioPkg::timerCount-1:0][ioPkg::dataWidth-1:0] count;
    logic [ioPkg::timerCount-1:0][ioPkg::regWidth-1:0]  destReg;
    logic [ioPkg::timerCount-1:0] running;
    logic [ioPkg::timerCount-1:0] due;
    logic [ioPkg::timerCount-1:0] wbBusy;
    logic [ioPkg::timerCount-1:0] expiring;
    logic [$clog2(ioPkg::timerCount)-1:0] sel;
    logic needsWb;
    logic accept;

    assign sel = cmd.addr[$clog2(ioPkg::timerCount)-1:0];

    // Zero reached; the writeback goes out once the port is free again
    assign due = running & countZero(count);
    assign wbBusy = wbReq | wbAck;
    assign expiring = due & ~wbBusy;

    assign needsWb = (cmd.minorOpcode == ioPkg::opTimerStart) ||
                     (cmd.minorOpcode == ioPkg::opTimerRead);

    // Start or read waits while the timer still owes a writeback
    assign accept = devReq && !devAck && !(needsWb && (wbBusy[sel] || due[sel]));

    function automatic logic [ioPkg::timerCount-1:0] countZero(
        input logic [ioPkg::timerCount-1:0][ioPkg::dataWidth-1:0] cnt
    );
        logic [ioPkg::timerCount-1:0] zero;
        for (int i = 0; i < ioPkg::timerCount; i++) begin
            zero[i] = (cnt[i] == '0);
        end
        return zero;
    endfunction

    always_ff @(posedge sys_clk) begin
        if (!rstN) begin
            devAck <= 1'b0;
            running <= '0;
            wbReq <= '0;
            period <= '0;
            count <= '0;
        end else begin
            if (!devReq) begin
                devAck <= 1'b0;
            end else if (accept) begin
                devAck <= 1'b1;
            end

            for (int i = 0; i < ioPkg::timerCount; i++) begin
                if (wbReq[i] && wbAck[i]) begin
                    wbReq[i] <= 1'b0;
                end
                if (expiring[i]) begin
                    running[i] <= 1'b0;
                    wbReq[i] <= 1'b1;
                end else if (running[i] && count[i] != '0) begin
                    count[i] <= count[i] - 1'b1;
                end
            end

            if (accept) begin
                case (cmd.minorOpcode)
                    ioPkg::opTimerLoad: period[sel] <= cmd.data;
                    ioPkg::opTimerStart: begin
                        count[sel] <= period[sel];
                        running[sel] <= 1'b1;
                    end
                    ioPkg::opTimerRead: wbReq[sel] <= 1'b1;
                    ioPkg::opTimerStop: running[sel] <= 1'b0; // No writeback
                    default: ;
                endcase
            end
        end
    end

    // Writeback payloads and the destination kept for expiry
    always_ff @(posedge sys_clk) begin
        for (int i = 0; i < ioPkg::timerCount; i++) begin
            if (expiring[i]) begin
                wb[i].destReg <= destReg[i];
                wb[i].data <= period[i];
            end
        end
        if (accept && cmd.minorOpcode == ioPkg::opTimerStart) begin
            destReg[sel] <= cmd.destReg;
        end
        if (accept && cmd.minorOpcode == ioPkg::opTimerRead) begin
            wb[sel].destReg <= cmd.destReg;
            wb[sel].data <= count[sel];
        end
    end

endmodule

//--- logic/gpioPortController.sv
`timescale 1ns/1ps

module gpioPortController (
    input  logic                        sys_clk,
    input  logic                        rstN,

    input  logic                        devReq,
    input  ioPkg::cmdT                  cmd,
    output logic                        devAck,

    output logic                        ioReq,
    output ioPkg::ioCmdT                ioOut,
    input  logic                        ioAck,
    input  logic                        respValid,
    input  logic                        respRegFlag,
    input  logic                        respMemFlag,
    input  logic [ioPkg::dataWidth-1:0] respData,

    output logic                        wbReq,
    output ioPkg::wbT                   wb,
    input  logic                        wbAck
);
    typedef enum logic [1:0] {
        stIdle,
        stSend,
        stAcked
    } stateT;

    stateT state;
    logic respPending;
    logic regDue;
    logic [ioPkg::dataWidth-1:0] respBuf;
    logic wbBusy;
    logic isRequest;
    logic isSend;
    logic isReadBuf;
    logic accept;
    logic regWb;

    assign wbBusy = wbReq || wbAck;
    assign isRequest = cmd.minorOpcode == ioPkg::opGpioRequest;
    assign isSend = isRequest || (cmd.minorOpcode == ioPkg::opGpioWrite);
    assign isReadBuf = cmd.minorOpcode == ioPkg::opGpioReadBuf;

    // Hold off while a response is outstanding or not yet written back
    assign accept = (state == stIdle) && devReq && !respPending && !regDue &&
                    !(isReadBuf && wbBusy);
    assign regWb = regDue && !wbBusy;

    always_ff @(posedge sys_clk) begin
        if (!rstN) begin
            state <= stIdle;
            devAck <= 1'b0;
            ioReq <= 1'b0;
            respPending <= 1'b0;
            regDue <= 1'b0;
            wbReq <= 1'b0;
            respBuf <= '0;
        end else begin
            if (wbReq && wbAck) begin
                wbReq <= 1'b0;
            end
            if (regWb) begin
                wbReq <= 1'b1;
                regDue <= 1'b0;
            end

            // Response pulse from the device
            if (respValid) begin
                respPending <= 1'b0;
                if (respRegFlag || respMemFlag) begin
                    respBuf <= respData;
                end
                if (respRegFlag) begin
                    regDue <= 1'b1;
                end
            end

            case (state)
                stIdle: begin
                    if (accept) begin
                        if (isSend) begin
                            ioReq <= 1'b1;
                            respPending <= isRequest;
                            state <= stSend;
                        end else begin
                            if (isReadBuf) begin
                                wbReq <= 1'b1;
                            end
                            devAck <= 1'b1;
                            state <= stAcked;
                        end
                    end
                end
                stSend: begin
                    if (ioAck) begin
                        ioReq <= 1'b0;
                        devAck <= 1'b1; // Core sees the ack only after the device took it
                        state <= stAcked;
                    end
                end
                stAcked: begin
                    if (!devReq && !ioAck) begin
                        devAck <= 1'b0;
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept && isSend) begin
            ioOut.responseRequested <= isRequest;
            ioOut.destReg <= cmd.destReg;
            ioOut.data <= cmd.data;
        end
        if (accept && isReadBuf) begin
            wb.destReg <= cmd.destReg;
            wb.data <= respBuf;
        end else if (regWb) begin
            wb.destReg <= ioOut.destReg; // Destination of the request sent out
            wb.data <= respBuf;
        end
    end

endmodule

//--- logic/ioManager.sv
`timescale 1ns/1ps

module ioManager (
    input  logic                        sys_clk,
    input  logic                        rstN,

    input  logic                        cmdReq,
    input  ioPkg::cmdT                  cmd,
    output logic                        cmdAck,

    output logic                        wbReq,
    output ioPkg::wbT                   wb,
    input  logic                        wbAck,

    output logic                        ioReq,
    output ioPkg::ioCmdT                ioOut,
    input  logic                        ioAck,
    input  logic                        respValid,
    input  logic                        respRegFlag, // Buffer and write back
    input  logic                        respMemFlag, // Buffer only
    input  logic [ioPkg::dataWidth-1:0] respData
);
    logic timerEn;
    logic gpioEn;
    logic unmapped;
    logic unmappedAck;
    logic timerAck;
    logic gpioAck;
    ioPkg::cmdT timerCmd;
    ioPkg::cmdT gpioCmd;

    logic [ioPkg::wbPortCount-1:0] wbReqArr;
    logic [ioPkg::wbPortCount-1:0] wbAckArr;
    ioPkg::wbT [ioPkg::wbPortCount-1:0] wbArr;

    assign timerEn = (cmd.addr >= ioPkg::ioBaseAddr + ioPkg::timerLowerAddr) &&
                     (cmd.addr <= ioPkg::ioBaseAddr + ioPkg::timerUpperAddr);
    assign gpioEn = (cmd.addr >= ioPkg::ioBaseAddr + ioPkg::gpioLowerAddr) &&
                    (cmd.addr <= ioPkg::ioBaseAddr + ioPkg::gpioUpperAddr);
    assign unmapped = !timerEn && !gpioEn;

    // Devices see their own offset
    always_comb begin
        timerCmd = cmd;
        timerCmd.addr = cmd.addr - ioPkg::ioBaseAddr - ioPkg::timerLowerAddr;
        gpioCmd = cmd;
        gpioCmd.addr = cmd.addr - ioPkg::ioBaseAddr - ioPkg::gpioLowerAddr;
    end

    // Nobody home, so acknowledge and drop
    always_ff @(posedge sys_clk) begin
        if (!rstN) begin
            unmappedAck <= 1'b0;
        end else begin
            unmappedAck <= cmdReq && unmapped;
        end
    end

    assign cmdAck = timerAck || gpioAck || unmappedAck;

    commandTimers systemTimers (
        .sys_clk(sys_clk),
        .rstN   (rstN),
        .devReq (cmdReq && timerEn),
        .cmd    (timerCmd),
        .devAck (timerAck),
        .wbAck  (wbAckArr[ioPkg::timerCount-1:0]),
        .wbReq  (wbReqArr[ioPkg::timerCount-1:0]),
        .wb     (wbArr[ioPkg::timerCount-1:0])
    );

    gpioPortController gpioPort (
        .sys_clk    (sys_clk),
        .rstN       (rstN),
        .devReq     (cmdReq && gpioEn),
        .cmd        (gpioCmd),
        .devAck     (gpioAck),
        .ioReq      (ioReq),
        .ioOut      (ioOut),
        .ioAck      (ioAck),
        .respValid  (respValid),
        .respRegFlag(respRegFlag),
        .respMemFlag(respMemFlag),
        .respData   (respData),
        .wbReq      (wbReqArr[ioPkg::timerCount]),
        .wb         (wbArr[ioPkg::timerCount]),
        .wbAck      (wbAckArr[ioPkg::timerCount])
    );

    writebackArbiter #(
        .portCount(ioPkg::wbPortCount)
    ) wbArbiter (
        .sys_clk(sys_clk),
        .rstN   (rstN),
        .inReq  (wbReqArr),
        .inWb   (wbArr),
        .inAck  (wbAckArr),
        .outReq (wbReq),
        .outWb  (wb),
        .outAck (wbAck)
    );

endmodule

//--- tests/ioManager_checker.sv
`timescale 1ns/1ps

module ioManager_checker (
    input logic       sys_clk,
    input logic       rstN,
    input logic       cmdReq,
    input logic       cmdAck,
    input logic       wbReq,
    input ioPkg::wbT  wb,
    input logic       wbAck,
    input logic       ioReq,
    input logic       ioAck
);
    int failCount = 0;

    wbHeld: assert property (@(posedge sys_clk) disable iff (!rstN)
        (wbReq && !wbAck) |=> $stable(wb))
    else begin
        $error("wb changed while wbReq waited for wbAck");
        failCount++;
    end

    cmdAckNeedsReq: assert property (@(posedge sys_clk) disable iff (!rstN)
        $rose(cmdAck) |-> cmdReq)
    else begin
        $error("cmdAck rose without cmdReq");
        failCount++;
    end

    ioReqHeld: assert property (@(posedge sys_clk) disable iff (!rstN)
        (ioReq && !ioAck) |=> ioReq)
    else begin
        $error("ioReq dropped before ioAck");
        failCount++;
    end

endmodule

bind ioManager ioManager_checker handshakeCheck (
    .sys_clk(sys_clk),
    .rstN   (rstN),
    .cmdReq (cmdReq),
    .cmdAck (cmdAck),
    .wbReq  (wbReq),
    .wb     (wb),
    .wbAck  (wbAck),
    .ioReq  (ioReq),
    .ioAck  (ioAck)
);

//--- tests/ioManagerMonitor.sv
`timescale 1ns/1ps

module ioManagerMonitor (
    input  logic          sys_clk,
    input  logic          rstN,
    input  logic          cmdReq,
    input  ioPkg::cmdT    cmd,
    input  logic          wbReq,
    input  ioPkg::wbT     wb,
    input  logic          ioReq,
    input  ioPkg::ioCmdT  ioOut,
    input  logic          expPush,
    input  logic [1:0]    expKind,
    input  ioPkg::wbT     expWb,
    input  logic          endOfTest,
    output int            checkCount,
    output int            errorCount,
    output int            pendingCount
);
    localparam logic [1:0] kindExact = 2'd1;
    localparam logic [1:0] kindAtMost = 2'd2; // Timer reads only bound the count

    ioPkg::wbT wantWb[$];
    logic [1:0] wantKind[$];
    ioPkg::ioCmdT wantLink[$];
    logic cmdReqPrev;
    logic wbReqPrev;
    logic ioReqPrev;
    logic swept;

    function automatic logic inGpioWindow(input logic [ioPkg::dataWidth-1:0] addr);
        return (addr >= ioPkg::ioBaseAddr + ioPkg::gpioLowerAddr) &&
               (addr <= ioPkg::ioBaseAddr + ioPkg::gpioUpperAddr);
    endfunction

    // Any order, exact entries before bounded ones
    task automatic takeWriteback(input ioPkg::wbT got);
        int hit;
        hit = -1;
        for (int i = 0; i < wantWb.size(); i++) begin
            if (hit < 0 && wantKind[i] == kindExact && wantWb[i] == got) begin
                hit = i;
            end
        end
        for (int i = 0; i < wantWb.size(); i++) begin
            if (hit < 0 && wantKind[i] == kindAtMost && wantWb[i].destReg == got.destReg &&
                got.data <= wantWb[i].data) begin
                hit = i;
            end
        end
        if (hit < 0) begin
            errorCount++;
            $display("error %0t: unexpected writeback to r%0d with data %h",
                     $time, got.destReg, got.data);
        end else begin
            checkCount++;
            wantWb.delete(hit);
            wantKind.delete(hit);
        end
    endtask

    task automatic checkLink(input ioPkg::ioCmdT got);
        ioPkg::ioCmdT want;
        if (wantLink.size() == 0) begin
            errorCount++;
            $display("error %0t: ioReq raised with no GPIO send outstanding, ioOut %h",
                     $time, got);
        end else begin
            want = wantLink.pop_front();
            if (got !== want) begin
                errorCount++;
                $display("error %0t: ioOut %h, expected %h", $time, got, want);
            end else begin
                checkCount++;
            end
        end
    endtask

    task automatic reportMissing();
        foreach (wantWb[i]) begin
            errorCount++;
            $display("Writeback to r%0d with data %h never arrived",
                     wantWb[i].destReg, wantWb[i].data);
        end
        foreach (wantLink[i]) begin
            errorCount++;
            $display("GPIO link transfer %h never appeared", wantLink[i]);
        end
        wantWb.delete();
        wantKind.delete();
        wantLink.delete();
    endtask

    always @(posedge sys_clk) begin
        if (!rstN) begin
            checkCount = 0;
            errorCount = 0;
            cmdReqPrev = 1'b0;
            wbReqPrev = 1'b0;
            ioReqPrev = 1'b0;
            swept = 1'b0;
            wantWb.delete();
            wantKind.delete();
            wantLink.delete();
        end else begin
            if (expPush) begin
                wantWb.push_back(expWb);
                wantKind.push_back(expKind);
            end
            // A GPIO write or request must show up on the outside link
            if (cmdReq && !cmdReqPrev && inGpioWindow(cmd.addr) &&
                (cmd.minorOpcode == ioPkg::opGpioWrite ||
                 cmd.minorOpcode == ioPkg::opGpioRequest)) begin
                wantLink.push_back({cmd.minorOpcode == ioPkg::opGpioRequest,
                                    cmd.destReg, cmd.data});
            end
            if (wbReq && !wbReqPrev) begin
                takeWriteback(wb);
            end
            if (ioReq && !ioReqPrev) begin
                checkLink(ioOut);
            end
            if (endOfTest && !swept) begin
                reportMissing();
                swept = 1'b1;
            end
            cmdReqPrev = cmdReq;
            wbReqPrev = wbReq;
            ioReqPrev = ioReq;
        end
        pendingCount = wantWb.size() + wantLink.size();
    end

endmodule

//--- tests/ioManagerTb.sv
`timescale 1ns/1ps

module ioManagerTb;
    localparam int fieldCount = 9;
    localparam int maxLines = 64;
    localparam int clkPeriod = 40;
    localparam int ackLimit = 2000;
    localparam int drainLimit = 3000;

    logic sys_clk;
    logic rstN = 1'b0;
    logic cmdReq = 1'b0;
    ioPkg::cmdT cmd = '0;
    logic cmdAck;
    logic wbReq;
    ioPkg::wbT wb;
    logic wbAck = 1'b0;
    logic ioReq;
    ioPkg::ioCmdT ioOut;
    logic ioAck = 1'b0;
    logic respValid = 1'b0;
    logic respRegFlag = 1'b0;
    logic respMemFlag = 1'b0;
    logic [ioPkg::dataWidth-1:0] respData = '0;

    logic expPush = 1'b0;
    logic [1:0] expKind = '0;
    ioPkg::wbT expWb = '0;
    logic endOfTest = 1'b0;
    int checkCount;
    int errorCount;
    int pendingCount;

    logic [15:0] stim [0:fieldCount*maxLines-1];
    int lineCount = 0;
    int handshakeErrors = 0;
    logic [17:0] respQueue[$]; // Flags above the data
    logic [17:0] respNext;
    int linkWait;
    int respWait;
    int ackDelay;

    ioManager ioManager_inst (
        .sys_clk    (sys_clk),
        .rstN       (rstN),
        .cmdReq     (cmdReq),
        .cmd        (cmd),
        .cmdAck     (cmdAck),
        .wbReq      (wbReq),
        .wb         (wb),
        .wbAck      (wbAck),
        .ioReq      (ioReq),
        .ioOut      (ioOut),
        .ioAck      (ioAck),
        .respValid  (respValid),
        .respRegFlag(respRegFlag),
        .respMemFlag(respMemFlag),
        .respData   (respData)
    );

    ioManagerMonitor monitor (
        .sys_clk     (sys_clk),
        .rstN        (rstN),
        .cmdReq      (cmdReq),
        .cmd         (cmd),
        .wbReq       (wbReq),
        .wb          (wb),
        .ioReq       (ioReq),
        .ioOut       (ioOut),
        .expPush     (expPush),
        .expKind     (expKind),
        .expWb       (expWb),
        .endOfTest   (endOfTest),
        .checkCount  (checkCount),
        .errorCount  (errorCount),
        .pendingCount(pendingCount)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(clkPeriod / 2) sys_clk = ~sys_clk;
    end

    // Period set by a timer load line, zero for any other line
    function automatic int loadedPeriod(input int at);
        if (stim[at][3:0] == ioPkg::opTimerLoad &&
            stim[at + 1] >= ioPkg::ioBaseAddr + ioPkg::timerLowerAddr &&
            stim[at + 1] <= ioPkg::ioBaseAddr + ioPkg::timerUpperAddr) begin
            return int'(stim[at + 2]);
        end
        return 0;
    endfunction

    task automatic announceWriteback(input logic [1:0] kind, input ioPkg::wbT want);
        @(posedge sys_clk);
        expPush <= 1'b1;
        expKind <= kind;
        expWb <= want;
        @(posedge sys_clk);
        expPush <= 1'b0;
    endtask

    task automatic issueCommand(input ioPkg::cmdT next);
        int waited;
        @(posedge sys_clk);
        cmd <= next;
        cmdReq <= 1'b1;
        waited = 0;
        do begin
            @(posedge sys_clk);
            waited++;
        end while (!cmdAck && waited < ackLimit);
        cmdReq <= 1'b0;
        if (!cmdAck) begin
            handshakeErrors++;
            $display("Command to address %h was never acknowledged", next.addr);
        end else begin
            waited = 0;
            while (cmdAck && waited < ackLimit) begin
                @(posedge sys_clk);
                waited++;
            end
            if (cmdAck) begin
                handshakeErrors++;
                $display("cmdAck stayed high after cmdReq dropped, address %h", next.addr);
            end
        end
    endtask

    task automatic runLine(input int at);
        ioPkg::cmdT next;
        next.minorOpcode = stim[at][3:0];
        next.addr = stim[at + 1];
        next.data = stim[at + 2];
        next.destReg = stim[at + 3][3:0];
        if (stim[at + 4] != 16'h0) begin
            announceWriteback(stim[at + 4][1:0], {stim[at + 5][3:0], stim[at + 6]});
        end
        if (stim[at + 7] != 16'h0) begin
            respQueue.push_back({stim[at + 7][1:0], stim[at + 8]});
        end
        issueCommand(next);
    endtask

    initial begin
        int seedValue;
        int waited;
        int totalErrors;
        int longestPeriod;
        seedValue = $urandom(56);
        $readmemh("tests/ioManager_stimulus.txt", stim);
        longestPeriod = 0;
        while (lineCount < maxLines && stim[lineCount * fieldCount] != 16'hffff) begin
            if (loadedPeriod(lineCount * fieldCount) > longestPeriod) begin
                longestPeriod = loadedPeriod(lineCount * fieldCount);
            end
            lineCount++;
        end
        repeat (3) @(posedge sys_clk);
        rstN <= 1'b1;
        @(posedge sys_clk);
        for (int n = 0; n < lineCount; n++) begin
            runLine(n * fieldCount);
        end
        // Timers may still owe writebacks
        waited = 0;
        @(negedge sys_clk);
        while (pendingCount != 0 && waited < drainLimit) begin
            @(negedge sys_clk);
            waited++;
        end
        // A stopped timer must stay quiet past its full period
        repeat (longestPeriod + 50) @(posedge sys_clk);
        endOfTest <= 1'b1;
        @(posedge sys_clk);
        @(negedge sys_clk);
        totalErrors = errorCount + handshakeErrors + ioManager_inst.handshakeCheck.failCount;
        $display("checks %0d, errors %0d", checkCount, totalErrors);
        if (totalErrors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Outside GPIO device
    always @(posedge sys_clk) begin
        if (!rstN) begin
            ioAck <= 1'b0;
            respValid <= 1'b0;
            linkWait <= 0;
            respWait <= 0;
        end else begin
            respValid <= 1'b0;
            if (ioReq && !ioAck) begin
                if (linkWait < 2) begin
                    linkWait <= linkWait + 1;
                end else begin
                    linkWait <= 0;
                    ioAck <= 1'b1;
                    if (ioOut.responseRequested && respQueue.size() > 0) begin
                        respNext <= respQueue.pop_front();
                        respWait <= 6;
                    end
                end
            end else if (!ioReq && ioAck) begin
                ioAck <= 1'b0;
            end
            if (respWait > 0) begin
                respWait <= respWait - 1;
                if (respWait == 1) begin
                    respValid <= 1'b1;
                    respRegFlag <= respNext[16];
                    respMemFlag <= respNext[17];
                    respData <= respNext[15:0];
                end
            end
        end
    end

    // Core side of the writeback channel, random delay per transfer
    always @(posedge sys_clk) begin
        if (!rstN) begin
            wbAck <= 1'b0;
            ackDelay <= 3;
        end else if (wbReq && !wbAck) begin
            if (ackDelay == 0) begin
                wbAck <= 1'b1;
            end else begin
                ackDelay <= ackDelay - 1;
            end
        end else if (!wbReq && wbAck) begin
            wbAck <= 1'b0;
            ackDelay <= int'($urandom % 13);
        end
    end

    initial begin
        int budget;
        #1;
        budget = lineCount * 400 * clkPeriod;
        #(budget);
        $display("Watchdog expired before the test sequence finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- tests/ioManager_stimulus.txt
// op addr data dest | wbKind wbDest wbData | respFlag respData
// wbKind 0 none, 1 exact, 2 data at most wbData; respFlag 0 none, 1 register, 2 buffer only
0 0100 1111 1 0 0 0000 0 0000 // Below the window
1 018e 2222 2 0 0 0000 0 0000 // Just past the GPIO range
2 0187 3333 3 0 0 0000 0 0000 // One below the timers
0 0188 0010 0 0 0 0000 0 0000
0 0189 000c 0 0 0 0000 0 0000
0 018a 0008 0 0 0 0000 0 0000
0 018b 0004 0 0 0 0000 0 0000
1 0188 0000 1 1 1 0010 0 0000 // Four timers expire close together
1 0189 0000 2 1 2 000c 0 0000
1 018a 0000 3 1 3 0008 0 0000
1 018b 0000 4 1 4 0004 0 0000
0 018c a5a5 9 0 0 0000 0 0000 // GPIO write, no response
1 018c 0011 a 1 a 1234 1 1234
1 018d 0022 b 0 0 0000 2 beef // Buffer only
2 018c 0000 c 1 c beef 0 0000
0 018a 00c8 0 0 0 0000 0 0000
1 018a 0000 5 1 5 00c8 0 0000
2 018a 0000 6 2 6 00c8 0 0000 // Read while counting
0 018b 01f4 0 0 0 0000 0 0000
1 018b 0000 7 0 0 0000 0 0000 // Stopped before expiry
3 018b 0000 0 0 0 0000 0 0000
ffff

//--- verilog.f
logic/ioPkg.sv
logic/writebackArbiter.sv
logic/commandTimers.sv
logic/gpioPortController.sv
logic/ioManager.sv
tests/ioManager_checker.sv
tests/ioManagerMonitor.sv
tests/ioManagerTb.sv

//--- Makefile
TOP = ioManagerTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f verilog.f

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
